// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define XLEN 8
`define ALEN 16

// 8080 register field codes with 6 left for M
`define REG_B 3'd0
`define REG_C 3'd1
`define REG_D 3'd2
`define REG_E 3'd3
`define REG_H 3'd4
`define REG_L 3'd5
`define REG_A 3'd7

`define OP_MVI_BASE 8'h06
`define OP_JMP      8'hC3
`define OP_JCC_BASE 8'hC2
`define OP_LDA      8'h3A
`define OP_STA      8'h32
`define OP_HLT      8'h76
`define OP_NOP      8'h00

`define RESET_PC 16'h0000

`endif

// ==== cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

    typedef enum logic [2:0] {T1, T2, T3, T4, T5, TW, TWH, TR} t_state_e;

    typedef enum logic [1:0] {M1, M2, M3, M4} m_cycle_e;

    // same order as the alu_op field of the opcode
    typedef enum logic [2:0] {
        ADD, ADC_UNUSED, SUB, SBB_UNUSED, AND, XOR, OR, CMP
    } alu_op_e;

    typedef enum logic [3:0] {
        MOV, MVI, ALU_REG, ALU_IMM, JMP, JCC, LDA, STA, HLT, NOP, ILLEGAL
    } instr_class_e;

    typedef struct packed {
        instr_class_e cls;
        logic [2:0]   sss;
        logic [2:0]   ddd;
        alu_op_e      alu_op;
        logic [1:0]   cc; // NZ, Z, NC, C
    } dec_s;

    typedef struct packed {
        logic s;
        logic z;
        logic c;
    } flags_s;

    typedef struct packed {
        logic [2:0] rd_sel;
        logic       rd_en; // tmp loads the selected register when set
        logic [2:0] wr_sel;
        logic       wr_en;
        logic       write_a;
        logic       write_tmp;
        logic       write_instr;
        logic       write_w;
        logic       write_z;
        logic       inc_pc;
        logic       adr_wz; // WZ as the address source
        logic       write_adr;
        alu_op_e    alu_op;
        logic       alu_en;
        logic       alu_no_wb;
        logic       write_data_out;
        logic       dout_tmp; // tmp as the data_out source
        logic       load_pc_from_wz;
    } ctrl_s;

    typedef struct packed {
        logic [`ALEN-1:0] addr;
        logic [`XLEN-1:0] data_out;
        logic             dbin;
        logic             write;
        logic             sync;
        logic             wwait;
        logic             m1;
        logic             hlta;
    } bus_s;

endpackage

// ==== instr_decode.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module instr_decode (
    input  logic [`XLEN-1:0] instr,
    output cpu_pkg::dec_s    dec
);

    logic op_kept;
    logic sss_m;
    logic ddd_m;

    assign op_kept = (instr[5:3] != 3'd1) && (instr[5:3] != 3'd3); // no ADC or SBB
    assign sss_m   = instr[2:0] == 3'd6;
    assign ddd_m   = instr[5:3] == 3'd6;

    always_comb begin
        dec.sss    = instr[2:0];
        dec.ddd    = instr[5:3];
        dec.alu_op = cpu_pkg::alu_op_e'(instr[5:3]);
        dec.cc     = instr[4:3];
        dec.cls    = cpu_pkg::ILLEGAL;

        case (instr[7:6])
            2'b00: begin
                if (instr == `OP_NOP) begin
                    dec.cls = cpu_pkg::NOP;
                end else if ((instr & 8'hC7) == `OP_MVI_BASE && !ddd_m) begin
                    dec.cls = cpu_pkg::MVI;
                end else if (instr == `OP_LDA) begin
                    dec.cls = cpu_pkg::LDA;
                end else if (instr == `OP_STA) begin
                    dec.cls = cpu_pkg::STA;
                end
            end
            2'b01: begin
                if (instr == `OP_HLT) begin
                    dec.cls = cpu_pkg::HLT;
                end else if (!sss_m && !ddd_m) begin
                    dec.cls = cpu_pkg::MOV;
                end
            end
            2'b10: begin
                if (op_kept && !sss_m) begin
                    dec.cls = cpu_pkg::ALU_REG;
                end
            end
            default: begin
                if (instr == `OP_JMP) begin
                    dec.cls = cpu_pkg::JMP;
                end else if ((instr & 8'hE7) == `OP_JCC_BASE) begin
                    dec.cls = cpu_pkg::JCC; // only NZ, Z, NC, C
                end else if (instr[2:0] == 3'd6 && op_kept) begin
                    dec.cls = cpu_pkg::ALU_IMM;
                end
            end
        endcase
    end

endmodule

// ==== cycle_sequencer.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cycle_sequencer (
    input  logic             clk,
    input  logic             is_rst,
    input  logic             ready,
    input  logic [`XLEN-1:0] data_in,
    input  cpu_pkg::dec_s    dec,
    input  cpu_pkg::flags_s  flags,
    output logic [`XLEN-1:0] instr,
    output cpu_pkg::ctrl_s   ctrl,
    output logic             dbin,
    output logic             write,
    output logic             sync,
    output logic             wwait,
    output logic             m1,
    output logic             hlta
);

    cpu_pkg::t_state_e t_state;
    cpu_pkg::t_state_e t_state_next;
    cpu_pkg::m_cycle_e m_cycle;
    cpu_pkg::m_cycle_e m_cycle_next;

    logic halt;
    logic take_jump;
    logic take_next;
    logic cond_met;
    logic data_in_en;
    logic data_out_en;
    logic mcycle_end;
    logic instr_end;
    logic hlt_req;
    logic write_ddd;
    logic use_wz;

    logic is_mov;
    logic is_mvi;
    logic is_alu_reg;
    logic is_alu_imm;
    logic is_jmp;
    logic is_jcc;
    logic is_lda;
    logic is_sta;

    assign is_mov     = dec.cls == cpu_pkg::MOV;
    assign is_mvi     = dec.cls == cpu_pkg::MVI;
    assign is_alu_reg = dec.cls == cpu_pkg::ALU_REG;
    assign is_alu_imm = dec.cls == cpu_pkg::ALU_IMM;
    assign is_jmp     = dec.cls == cpu_pkg::JMP;
    assign is_jcc     = dec.cls == cpu_pkg::JCC;
    assign is_lda     = dec.cls == cpu_pkg::LDA;
    assign is_sta     = dec.cls == cpu_pkg::STA;

    always_comb begin
        case (dec.cc)
            2'd0:    cond_met = !flags.z;
            2'd1:    cond_met = flags.z;
            2'd2:    cond_met = !flags.c;
            default: cond_met = flags.c;
        endcase
    end

    assign take_next = is_jmp || (is_jcc && cond_met);

    always_comb begin
        ctrl        = '0;
        ctrl.rd_sel = dec.sss;
        ctrl.wr_sel = dec.ddd;
        ctrl.alu_op = dec.alu_op;
        data_in_en  = 1'b0;
        data_out_en = 1'b0;
        mcycle_end  = 1'b0;
        instr_end   = 1'b0;
        hlt_req     = 1'b0;
        write_ddd   = 1'b0;
        use_wz      = 1'b0;

        if (t_state == cpu_pkg::TR) begin
            instr_end = 1'b1; // first fetch from PC
        end else begin
            case ({m_cycle, t_state})
                {cpu_pkg::M1, cpu_pkg::T1}: ctrl.inc_pc = 1'b1;
                {cpu_pkg::M1, cpu_pkg::T2}, {cpu_pkg::M1, cpu_pkg::TW}: begin
                    data_in_en       = 1'b1;
                    ctrl.write_instr = 1'b1;
                end
                {cpu_pkg::M1, cpu_pkg::T3}: begin
                    if (is_mov || is_alu_reg) begin
                        ctrl.rd_en     = 1'b1;
                        ctrl.write_tmp = 1'b1;
                    end
                end
                {cpu_pkg::M1, cpu_pkg::T4}: begin
                    case (dec.cls)
                        cpu_pkg::MOV: begin
                            write_ddd = 1'b1;
                            instr_end = 1'b1;
                        end
                        cpu_pkg::ALU_REG: begin
                            ctrl.alu_en    = 1'b1;
                            ctrl.alu_no_wb = dec.alu_op == cpu_pkg::CMP;
                            instr_end      = 1'b1;
                        end
                        cpu_pkg::HLT: hlt_req = 1'b1;
                        cpu_pkg::NOP, cpu_pkg::ILLEGAL: instr_end = 1'b1;
                        default: begin
                            mcycle_end     = 1'b1; // operand fetch from PC
                            ctrl.write_adr = 1'b1;
                        end
                    endcase
                end
                {cpu_pkg::M1, cpu_pkg::T5}: instr_end = 1'b1;
                {cpu_pkg::M2, cpu_pkg::T1}, {cpu_pkg::M3, cpu_pkg::T1}: ctrl.inc_pc = 1'b1;
                {cpu_pkg::M2, cpu_pkg::T2}, {cpu_pkg::M2, cpu_pkg::TW}: begin
                    data_in_en = 1'b1;
                    if (is_mvi || is_alu_imm) begin
                        ctrl.write_tmp = 1'b1;
                    end else begin
                        ctrl.write_z = 1'b1; // low byte of address
                    end
                end
                {cpu_pkg::M2, cpu_pkg::T3}: begin
                    if (is_mvi) begin
                        write_ddd = 1'b1;
                        instr_end = 1'b1;
                    end else if (is_alu_imm) begin
                        ctrl.alu_en    = 1'b1;
                        ctrl.alu_no_wb = dec.alu_op == cpu_pkg::CMP;
                        instr_end      = 1'b1;
                    end else begin
                        mcycle_end     = 1'b1;
                        ctrl.write_adr = 1'b1;
                    end
                end
                {cpu_pkg::M3, cpu_pkg::T2}, {cpu_pkg::M3, cpu_pkg::TW}: begin
                    data_in_en   = 1'b1;
                    ctrl.write_w = 1'b1;
                end
                {cpu_pkg::M3, cpu_pkg::T3}: begin
                    if (is_lda || is_sta) begin
                        mcycle_end     = 1'b1;
                        ctrl.adr_wz    = 1'b1;
                        ctrl.write_adr = 1'b1;
                    end else begin
                        instr_end = 1'b1;
                        use_wz    = take_jump;
                    end
                end
                {cpu_pkg::M4, cpu_pkg::T1}: ctrl.write_data_out = is_sta;
                {cpu_pkg::M4, cpu_pkg::T2}, {cpu_pkg::M4, cpu_pkg::TW}: begin
                    data_in_en     = is_lda;
                    ctrl.write_tmp = is_lda;
                    data_out_en    = is_sta;
                end
                {cpu_pkg::M4, cpu_pkg::T3}: begin
                    ctrl.write_a = is_lda;
                    instr_end    = 1'b1;
                end
                default: ;
            endcase
        end

        if (write_ddd) begin
            if (dec.ddd == `REG_A) begin
                ctrl.write_a = 1'b1;
            end else begin
                ctrl.wr_en = 1'b1;
            end
        end

        if (halt || hlt_req) begin
            m_cycle_next = cpu_pkg::M1;
            t_state_next = cpu_pkg::TWH;
        end else if ((t_state == cpu_pkg::T2 || t_state == cpu_pkg::TW) && !ready) begin
            m_cycle_next = m_cycle;
            t_state_next = cpu_pkg::TW;
        end else if (instr_end) begin
            m_cycle_next         = cpu_pkg::M1;
            t_state_next         = cpu_pkg::T1;
            ctrl.write_adr       = 1'b1;
            ctrl.adr_wz          = use_wz;
            ctrl.load_pc_from_wz = use_wz;
        end else if (mcycle_end) begin
            m_cycle_next = cpu_pkg::m_cycle_e'(m_cycle + 2'd1);
            t_state_next = cpu_pkg::T1;
        end else begin
            m_cycle_next = m_cycle;
            case (t_state)
                cpu_pkg::T1:             t_state_next = cpu_pkg::T2;
                cpu_pkg::T2, cpu_pkg::TW: t_state_next = cpu_pkg::T3;
                cpu_pkg::T3:             t_state_next = cpu_pkg::T4;
                default:                 t_state_next = cpu_pkg::T5;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (is_rst) begin
            t_state   <= cpu_pkg::TR;
            m_cycle   <= cpu_pkg::M1;
            halt      <= 1'b0;
            take_jump <= 1'b0;
        end else begin
            t_state <= t_state_next;
            m_cycle <= m_cycle_next;
            halt    <= halt || hlt_req;
            if (m_cycle == cpu_pkg::M1 && t_state == cpu_pkg::T4) begin
                take_jump <= take_next; // flags settled by now
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.write_instr) begin
            instr <= data_in;
        end
    end

    assign dbin  = data_in_en;
    assign write = data_out_en;
    assign sync  = t_state == cpu_pkg::T1;
    assign wwait = (t_state == cpu_pkg::TW) || (t_state == cpu_pkg::TWH);
    assign m1    = (m_cycle == cpu_pkg::M1) && (t_state != cpu_pkg::TWH);
    assign hlta  = halt;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module reg_file (
    input  logic             clk,
    input  logic             is_rst,
    input  cpu_pkg::ctrl_s   ctrl,
    input  logic [`XLEN-1:0] data_in,
    input  logic [`XLEN-1:0] alu_result,
    output logic [`XLEN-1:0] a_val,
    output logic [`XLEN-1:0] tmp_val,
    output logic [`ALEN-1:0] addr,
    output logic [`XLEN-1:0] data_out
);

    logic [`XLEN-1:0] gpr [0:5]; // B C D E H L
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] tmp;
    logic [`XLEN-1:0] w;
    logic [`XLEN-1:0] z;
    logic [`XLEN-1:0] rd_val;
    logic [`ALEN-1:0] pc;
    logic [`ALEN-1:0] pc_inc;

    assign pc_inc = pc + `ALEN'(1);

    always_comb begin
        case (ctrl.rd_sel)
            `REG_B, `REG_C, `REG_D, `REG_E, `REG_H, `REG_L: rd_val = gpr[ctrl.rd_sel];
            `REG_A:  rd_val = a;
            default: rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (is_rst) begin
            pc   <= `RESET_PC;
            addr <= `RESET_PC;
        end else begin
            if (ctrl.load_pc_from_wz) begin
                pc <= {w, z};
            end else if (ctrl.inc_pc) begin
                pc <= pc_inc;
            end
            if (ctrl.write_adr) begin
                addr <= ctrl.adr_wz ? {w, z} : pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.write_tmp) begin
            tmp <= ctrl.rd_en ? rd_val : data_in;
        end
        if (ctrl.wr_en) begin
            gpr[ctrl.wr_sel] <= tmp;
        end
        if (ctrl.write_a) begin
            a <= tmp;
        end else if (ctrl.alu_en && !ctrl.alu_no_wb) begin
            a <= alu_result;
        end
        if (ctrl.write_w) begin
            w <= data_in;
        end
        if (ctrl.write_z) begin
            z <= data_in;
        end
        if (ctrl.write_data_out) begin
            data_out <= ctrl.dout_tmp ? tmp : a;
        end
    end

    assign a_val   = a;
    assign tmp_val = tmp;

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module alu (
    input  logic             clk,
    input  logic             is_rst,
    input  cpu_pkg::ctrl_s   ctrl,
    input  logic [`XLEN-1:0] a_val,
    input  logic [`XLEN-1:0] tmp_val,
    output logic [`XLEN-1:0] result,
    output cpu_pkg::flags_s  flags
);

    logic [`XLEN:0] sum;
    logic [`XLEN:0] diff;
    logic           carry;

    assign sum  = {1'b0, a_val} + {1'b0, tmp_val};
    assign diff = {1'b0, a_val} - {1'b0, tmp_val}; // top bit is the borrow

    always_comb begin
        carry = 1'b0;
        case (ctrl.alu_op)
            cpu_pkg::ADD: begin
                result = sum[`XLEN-1:0];
                carry  = sum[`XLEN];
            end
            cpu_pkg::SUB, cpu_pkg::CMP: begin
                result = diff[`XLEN-1:0];
                carry  = diff[`XLEN];
            end
            cpu_pkg::AND: result = a_val & tmp_val;
            cpu_pkg::XOR: result = a_val ^ tmp_val;
            cpu_pkg::OR:  result = a_val | tmp_val;
            default:      result = a_val; // ADC/SBB never decoded
        endcase
    end

    always_ff @(posedge clk) begin
        if (is_rst) begin
            flags <= '0;
        end else if (ctrl.alu_en) begin
            flags.s <= result[`XLEN-1];
            flags.z <= result == '0;
            flags.c <= carry;
        end
    end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_top (
    input  logic             clk,
    input  logic             is_rst,
    input  logic             ready,
    input  logic [`XLEN-1:0] data_in,
    output cpu_pkg::bus_s    bus
);

    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] a_val;
    logic [`XLEN-1:0] tmp_val;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] data_out;
    logic [`ALEN-1:0] addr;
    logic             dbin;
    logic             write;
    logic             sync;
    logic             wwait;
    logic             m1;
    logic             hlta;
    cpu_pkg::dec_s    dec;
    cpu_pkg::ctrl_s   ctrl;
    cpu_pkg::flags_s  flags;

    cycle_sequencer u_seq (
        .clk     (clk),
        .is_rst  (is_rst),
        .ready   (ready),
        .data_in (data_in),
        .dec     (dec),
        .flags   (flags),
        .instr   (instr),
        .ctrl    (ctrl),
        .dbin    (dbin),
        .write   (write),
        .sync    (sync),
        .wwait   (wwait),
        .m1      (m1),
        .hlta    (hlta)
    );

    instr_decode u_dec (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_regs (
        .clk        (clk),
        .is_rst     (is_rst),
        .ctrl       (ctrl),
        .data_in    (data_in),
        .alu_result (alu_result),
        .a_val      (a_val),
        .tmp_val    (tmp_val),
        .addr       (addr),
        .data_out   (data_out)
    );

    alu u_alu (
        .clk     (clk),
        .is_rst  (is_rst),
        .ctrl    (ctrl),
        .a_val   (a_val),
        .tmp_val (tmp_val),
        .result  (alu_result),
        .flags   (flags)
    );

    assign bus = '{addr: addr, data_out: data_out, dbin: dbin, write: write,
                   sync: sync, wwait: wwait, m1: m1, hlta: hlta};

endmodule

// ==== tb_cpu_assertions.sv ====
`timescale 1ns/10ps

module tb_cpu_assertions (
    input logic          clk,
    input logic          is_rst,
    input cpu_pkg::bus_s bus
);

    int fail_count = 0;

    a_no_read_write: assert property (@(posedge clk) disable iff (is_rst)
        !(bus.dbin && bus.write))
        else begin
            $error("dbin and write high in the same clock");
            fail_count++;
        end

    a_single_sync: assert property (@(posedge clk) disable iff (is_rst)
        bus.sync |=> !bus.sync)
        else begin
            $error("sync high for two clocks in a row");
            fail_count++;
        end

    // wait states freeze the address latch
    a_addr_hold: assert property (@(posedge clk) disable iff (is_rst)
        bus.wwait |-> $stable(bus.addr))
        else begin
            $error("addr changed during a wait state");
            fail_count++;
        end

    a_no_write_halted: assert property (@(posedge clk) disable iff (is_rst)
        !(bus.write && bus.hlta))
        else begin
            $error("write high while halted");
            fail_count++;
        end

endmodule

bind cpu_top tb_cpu_assertions u_assert (
    .clk    (clk),
    .is_rst (is_rst),
    .bus    (bus)
);

// ==== tb_cpu.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module tb_cpu;

    localparam int         WAIT_LIMIT = 300;
    localparam logic [7:0] ALU_X      = 8'h9C;
    localparam logic [7:0] ALU_Y      = 8'h5B;

    logic             clk;
    logic             is_rst;
    logic             ready;
    logic [`XLEN-1:0] data_in;
    cpu_pkg::bus_s    bus;

    logic [7:0]  mem [0:255];
    logic [16:0] sync_q [$]; // {m1, addr}
    logic [15:0] fetch_q [$];
    logic [23:0] wr_q [$];   // {addr, data}
    int          wait_clocks = 0;
    bit          halted = 1'b0;
    bit          stress = 1'b0;
    logic [31:0] lcg_state = 32'd10995;

    int          s_base;
    int          f_base;
    int          w_base;
    int          wc_base;
    int          err_base;
    int          load_ptr;
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    logic [15:0] alu_ref_addr;
    logic [7:0]  alu_ref_data;

    cpu_top u_dut (
        .clk     (clk),
        .is_rst  (is_rst),
        .ready   (ready),
        .data_in (data_in),
        .bus     (bus)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // memory read side and ready driven just after the edge
    initial begin
        ready   = 1'b1;
        data_in = 8'h00;
        forever begin
            @(posedge clk);
            #1;
            if (stress) begin
                lcg_state = lcg_next(lcg_state);
                ready     = lcg_state[18:17] != 2'b00; // low about one clock in four
            end else begin
                ready = 1'b1;
            end
            data_in = bus.dbin ? mem[bus.addr[7:0]] : 8'h00;
        end
    end

    always @(negedge clk) begin
        if (!is_rst) begin
            if (bus.sync) begin
                sync_q.push_back({bus.m1, bus.addr});
                if (bus.m1) begin
                    fetch_q.push_back(bus.addr);
                end
            end
            if (bus.write && ready) begin
                wr_q.push_back({bus.addr, bus.data_out}); // last clock of the write
            end
            if (bus.wwait) begin
                wait_clocks++;
            end
        end
        halted = !is_rst && bus.hlta && bus.wwait;
    end

    // reference ALU returning {carry, result}
    function automatic logic [8:0] alu_model(input cpu_pkg::alu_op_e op, input logic [7:0] a,
                                             input logic [7:0] b);
        case (op)
            cpu_pkg::ADD:               return {1'b0, a} + {1'b0, b};
            cpu_pkg::SUB, cpu_pkg::CMP: return {a < b, 8'(a - b)};
            cpu_pkg::AND:               return {1'b0, a & b};
            cpu_pkg::XOR:               return {1'b0, a ^ b};
            cpu_pkg::OR:                return {1'b0, a | b};
            default:                    return {1'b0, a};
        endcase
    endfunction

    function automatic logic [7:0] mvi(input logic [2:0] r);
        return `OP_MVI_BASE | {2'b00, r, 3'b000};
    endfunction

    function automatic logic [7:0] mov(input logic [2:0] d, input logic [2:0] s);
        return {2'b01, d, s};
    endfunction

    function automatic logic [7:0] alu_reg(input cpu_pkg::alu_op_e op, input logic [2:0] s);
        return {2'b10, op, s};
    endfunction

    function automatic logic [7:0] alu_imm(input cpu_pkg::alu_op_e op);
        return {2'b11, op, 3'b110};
    endfunction

    function automatic logic [7:0] jcc(input logic [1:0] cc);
        return `OP_JCC_BASE | {3'b000, cc, 3'b000};
    endfunction

    task automatic org(input int a);
        load_ptr = a;
    endtask

    task automatic emit(input logic [7:0] b);
        mem[load_ptr[7:0]] = b;
        load_ptr++;
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)] = 8'(i) ^ 8'hA5;
        end
    endtask

    task automatic check_hex(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp)
        else begin
            $display("ERROR %s expected 0x%h got 0x%h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond)
        else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    task automatic begin_test();
        @(posedge clk);
        #1;
        is_rst   = 1'b1;
        s_base   = sync_q.size();
        f_base   = fetch_q.size();
        w_base   = wr_q.size();
        wc_base  = wait_clocks;
        err_base = errors;
        fill_memory();
    endtask

    task automatic release_reset();
        repeat (16) @(posedge clk);
        #1;
        is_rst = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_base) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: failed", tests, name);
        end
    endtask

    task automatic wait_syncs(input int n, input string what);
        int cycles;
        cycles = 0;
        while (sync_q.size() < s_base + n && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        check_true(sync_q.size() >= s_base + n, {"timeout waiting for ", what});
    endtask

    task automatic wait_fetches(input int n, input string what);
        int cycles;
        cycles = 0;
        while (fetch_q.size() < f_base + n && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        check_true(fetch_q.size() >= f_base + n, {"timeout waiting for ", what});
    endtask

    task automatic wait_writes(input int n, input string what);
        int cycles;
        cycles = 0;
        while (wr_q.size() < w_base + n && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        check_true(wr_q.size() >= w_base + n, {"timeout waiting for ", what});
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        while (!halted && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        check_true(halted, "timeout waiting for hlta and wwait after HLT");
    endtask

    task automatic test_reset();
        begin_test();
        org(0);
        emit(`OP_NOP);
        emit(`OP_HLT);
        release_reset();
        wait_syncs(1, "the first sync after reset");
        if (sync_q.size() > s_base) begin
            check_hex("addr", sync_q[s_base][15:0], `RESET_PC);
            check_hex("m1", 16'(sync_q[s_base][16]), 16'h0001);
            check_true(wr_q.size() == w_base, "a write occurred before the first sync");
        end
        end_test("reset");
    endtask

    task automatic load_alu_program();
        org(0);
        emit(mvi(`REG_A));
        emit(ALU_X);
        emit(mvi(`REG_B));
        emit(ALU_Y);
        emit(mov(`REG_C, `REG_B));
        emit(alu_reg(cpu_pkg::ADD, `REG_C));
        emit(alu_reg(cpu_pkg::SUB, `REG_B));
        emit(alu_reg(cpu_pkg::XOR, `REG_B));
        emit(alu_reg(cpu_pkg::OR, `REG_B));
        emit(alu_reg(cpu_pkg::AND, `REG_B));
        emit(`OP_STA);
        emit(8'h80);
        emit(8'h00);
        emit(`OP_HLT);
    endtask

    task automatic check_alu_store();
        wait_writes(1, "the STA of the ALU result");
        if (wr_q.size() > w_base) begin
            check_hex("write addr", wr_q[w_base][23:8], alu_ref_addr);
            check_hex("write data", 16'(wr_q[w_base][7:0]), 16'(alu_ref_data));
        end
    endtask

    task automatic test_alu_path();
        logic [8:0] r;
        logic [7:0] acc;
        begin_test();
        load_alu_program();
        acc = ALU_X;
        r   = alu_model(cpu_pkg::ADD, acc, ALU_Y); // C holds a copy of B
        acc = r[7:0];
        r   = alu_model(cpu_pkg::SUB, acc, ALU_Y);
        acc = r[7:0];
        r   = alu_model(cpu_pkg::XOR, acc, ALU_Y);
        acc = r[7:0];
        r   = alu_model(cpu_pkg::OR, acc, ALU_Y);
        acc = r[7:0];
        r   = alu_model(cpu_pkg::AND, acc, ALU_Y);
        alu_ref_addr = 16'h0080;
        alu_ref_data = r[7:0];
        release_reset();
        check_alu_store();
        end_test("register alu path");
    endtask

    task automatic run_cmp_jump(input string name, input logic [7:0] a, input logic [7:0] imm,
                                input logic [1:0] cc);
        logic [8:0]  r;
        logic        z;
        logic        c;
        logic        taken;
        logic [15:0] exp_target;
        begin_test();
        org(0);
        emit(mvi(`REG_A));
        emit(a);
        emit(alu_imm(cpu_pkg::CMP));
        emit(imm);
        emit(jcc(cc));
        emit(8'h40);
        emit(8'h00);
        emit(`OP_STA); // fall-through path at 0x07
        emit(8'h82);
        emit(8'h00);
        emit(`OP_HLT);
        org('h40);
        emit(`OP_STA);
        emit(8'h81);
        emit(8'h00);
        emit(`OP_HLT);
        r = alu_model(cpu_pkg::CMP, a, imm);
        z = r[7:0] == 8'h00;
        c = r[8];
        case (cc)
            2'd0:    taken = !z;
            2'd1:    taken = z;
            2'd2:    taken = !c;
            default: taken = c;
        endcase
        exp_target = taken ? 16'h0040 : 16'h0007;
        release_reset();
        wait_fetches(4, "the fetch after the conditional jump");
        if (fetch_q.size() >= f_base + 4) begin
            check_hex("fetch addr", fetch_q[f_base + 3], exp_target);
        end
        wait_writes(1, "the STA after the jump");
        if (wr_q.size() > w_base) begin
            check_hex("write addr", wr_q[w_base][23:8], taken ? 16'h0081 : 16'h0082);
            check_hex("write data", 16'(wr_q[w_base][7:0]), 16'(a));
        end
        end_test(name);
    endtask

    task automatic test_lda();
        logic [7:0] d;
        logic [7:0] exp;
        d   = 8'hFF; // wraps on the add
        exp = d + 8'd1;
        begin_test();
        mem[8'h90] = d;
        org(0);
        emit(`OP_LDA);
        emit(8'h90);
        emit(8'h00);
        emit(alu_imm(cpu_pkg::ADD));
        emit(8'h01);
        emit(`OP_STA);
        emit(8'h91);
        emit(8'h00);
        emit(`OP_HLT);
        release_reset();
        wait_writes(1, "the STA after LDA");
        if (wr_q.size() > w_base) begin
            check_hex("write addr", wr_q[w_base][23:8], 16'h0091);
            check_hex("write data", 16'(wr_q[w_base][7:0]), 16'(exp));
        end
        end_test("lda and add immediate");
    endtask

    task automatic test_wait_states();
        begin_test();
        load_alu_program();
        stress = 1'b1;
        release_reset();
        check_alu_store();
        stress = 1'b0;
        check_true(wait_clocks > wc_base, "no wait state was inserted during the ready stress");
        end_test("wait states");
    endtask

    task automatic test_halt();
        int s_halt;
        int w_halt;
        begin_test();
        org(0);
        emit(`OP_NOP);
        emit(`OP_HLT);
        release_reset();
        wait_halt();
        s_halt = sync_q.size();
        w_halt = wr_q.size();
        repeat (50) @(posedge clk);
        check_true(sync_q.size() == s_halt, "sync appeared while halted");
        check_true(wr_q.size() == w_halt, "write appeared while halted");
        check_true(halted, "the core left the halt state");
        end_test("halt");
    endtask

    initial begin
        is_rst = 1'b1;
        test_reset();
        test_alu_path();
        run_cmp_jump("cmp equal then jz", 8'h37, 8'h37, 2'd1);
        run_cmp_jump("cmp larger then jnc", 8'h21, 8'h64, 2'd2);
        test_lda();
        test_wait_states();
        test_halt();
        errors += u_dut.u_assert.fail_count;
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
cpu_pkg.sv
instr_decode.sv
cycle_sequencer.sv
reg_file.sv
alu.sv
cpu_top.sv
tb_cpu_assertions.sv
tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert -f sim.f --top-module tb_cpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
